// File: verilog/rp_pkg.sv
// --------------------
// shared widths, bus types and register map of the ADC to DAC loop
// compiled before every other source, used through rp_pkg:: names
// --------------------
package rp_pkg;

  // -------------------- widths
  localparam int SMP_W      = 14;                // converter sample width
  localparam int SUM_W      = SMP_W + 1;         // one guard bit for the adder
  localparam int BUS_W      = 32;                // system bus width
  localparam int N_REGIONS  = 8;                 // regions on the system bus
  localparam int REGION_W   = $clog2(N_REGIONS); // width of the region field
  localparam int REGION_LSB = 20;                // region field is addr[22:20]
  localparam int LED_W      = 8;                 // board LEDs

  // -------------------- types
  typedef logic        [SMP_W-1:0]     adc_raw_t;    // raw pin code, neg slope
  typedef logic signed [SMP_W-1:0]     sample_t;     // two's complement sample
  typedef logic signed [SUM_W-1:0]     sum_t;        // sum before saturation
  typedef logic        [SMP_W-1:0]     dac_code_t;   // code on the DAC pins
  typedef logic        [BUS_W-1:0]     sys_addr_t;
  typedef logic        [BUS_W-1:0]     sys_data_t;
  typedef logic        [N_REGIONS-1:0] region_sel_t; // one-hot region select
  typedef enum logic { ph_a, ph_b }    dac_phase_t;  // DAC channel phase

  // -------------------- register map
  localparam int REGION_HK = 0;                  // housekeeping
  localparam int REGION_DC = 1;                  // DC source

  localparam logic [REGION_LSB-1:0] HK_ID_OFS    = 'h00;
  localparam logic [REGION_LSB-1:0] HK_LED_OFS   = 'h30;
  localparam sys_data_t             HK_ID_VALUE  = 32'h5250_0001;

  localparam logic [REGION_LSB-1:0] DC_CTRL_OFS  = 'h00;
  localparam logic [REGION_LSB-1:0] DC_OFS_A_OFS = 'h04;
  localparam logic [REGION_LSB-1:0] DC_OFS_B_OFS = 'h08;
  localparam int                    DC_LOOP_A_BIT = 0; // ctrl bit, loopback on A
  localparam int                    DC_LOOP_B_BIT = 1; // ctrl bit, loopback on B

  // -------------------- saturation limits
  localparam sample_t SAMPLE_MAX = 14'h1FFF;     // +8191
  localparam sample_t SAMPLE_MIN = 14'h2000;     // -8192

endpackage

// File: verilog/sys_bus_decoder.sv
// --------------------
// system bus region decoder on addr[22:20]
// fans wen/ren out to the mapped regions, muxes their answers back
// and answers unmapped regions itself with ack + err, zero data
// --------------------
`timescale 1ns/1ps

module sys_bus_decoder (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  rp_pkg::sys_addr_t sys_addr_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  output rp_pkg::sys_data_t sys_rdata_o,
  output logic              sys_ack_o,
  output logic              sys_err_o,
  output logic              hk_wen_o,   // region 0 strobes
  output logic              hk_ren_o,
  output logic              dc_wen_o,   // region 1 strobes
  output logic              dc_ren_o,
  input  rp_pkg::sys_data_t hk_rdata_i,
  input  logic              hk_ack_i,
  input  logic              hk_err_i,
  input  rp_pkg::sys_data_t dc_rdata_i,
  input  logic              dc_ack_i,
  input  logic              dc_err_i
);

  logic [rp_pkg::REGION_W-1:0] region;     // region field of the address
  rp_pkg::region_sel_t         sel;        // one-hot select
  logic                        sel_hk, sel_dc;
  logic                        own_ack_q;  // answer for unmapped regions

  assign region = sys_addr_i[rp_pkg::REGION_LSB +: rp_pkg::REGION_W];
  assign sel    = rp_pkg::region_sel_t'(1) << region;
  assign sel_hk = sel[rp_pkg::REGION_HK];
  assign sel_dc = sel[rp_pkg::REGION_DC];

  // -------------------- strobe fan-out
  assign hk_wen_o = sys_wen_i & sel_hk;
  assign hk_ren_o = sys_ren_i & sel_hk;
  assign dc_wen_o = sys_wen_i & sel_dc;
  assign dc_ren_o = sys_ren_i & sel_dc;

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      own_ack_q <= 1'b0;
    end else begin
      own_ack_q <= (sys_wen_i | sys_ren_i) & ~(sel_hk | sel_dc); // regions 2..7
    end
  end

  // -------------------- answer mux, addr is held until ack
  always_comb begin
    sys_rdata_o = '0;                      // unmapped regions read zero
    if (sel_hk) begin
      sys_rdata_o = hk_rdata_i;
    end else if (sel_dc) begin
      sys_rdata_o = dc_rdata_i;
    end
  end

  assign sys_ack_o = (sel_hk & hk_ack_i) | (sel_dc & dc_ack_i) | own_ack_q;
  assign sys_err_o = (sel_hk & hk_err_i) | (sel_dc & dc_err_i) | own_ack_q;

  wen_ren_excl: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i) !(sys_wen_i && sys_ren_i)
  );

endmodule

// File: verilog/housekeeping_regs.sv
// --------------------
// region 0 housekeeping registers
// 0x00 ID word (read only), 0x30 LED register (read/write)
// --------------------
`timescale 1ns/1ps

module housekeeping_regs (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,
  input  rp_pkg::sys_addr_t        addr_i,
  input  rp_pkg::sys_data_t        wdata_i,
  input  logic                     wen_i,
  input  logic                     ren_i,
  output rp_pkg::sys_data_t        rdata_o,
  output logic                     ack_o,
  output logic                     err_o,
  output logic [rp_pkg::LED_W-1:0] led_o
);

  logic [rp_pkg::REGION_LSB-1:0] ofs;      // offset inside the region
  logic                          hit_id, hit_led;
  logic [rp_pkg::LED_W-1:0]      led_q;
  logic                          ack_q, err_q;
  rp_pkg::sys_data_t             rdata_q;

  assign ofs     = addr_i[rp_pkg::REGION_LSB-1:0];
  assign hit_id  = (ofs == rp_pkg::HK_ID_OFS);
  assign hit_led = (ofs == rp_pkg::HK_LED_OFS);

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      led_q <= '0;
    end else begin
      ack_q <= wen_i | ren_i;                               // answer next cycle
      err_q <= (wen_i & ~hit_led) | (ren_i & ~(hit_id | hit_led)); // ID is read only
      if (wen_i && hit_led) begin
        led_q <= wdata_i[rp_pkg::LED_W-1:0];
      end
    end
  end

  // read data
  always_ff @(posedge adc_clk) begin
    if (ren_i && hit_id)       rdata_q <= rp_pkg::HK_ID_VALUE;
    else if (ren_i && hit_led) rdata_q <= rp_pkg::sys_data_t'(led_q);
    else                       rdata_q <= '0;               // writes, unknown offsets
  end

  assign rdata_o = rdata_q;
  assign ack_o   = ack_q;
  assign err_o   = err_q;
  assign led_o   = led_q;

  // holds only while the master waits for ack before the next pulse
  ack_one_cycle: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i) ack_q |=> !ack_q
  );

endmodule

// File: verilog/dc_source_regs.sv
// --------------------
// region 1 DC source registers
// 0x00 ctrl: bit 0 loopback on A, bit 1 loopback on B
// 0x04 / 0x08 offsets A / B, low 14 bits of wdata, read back sign-extended
// --------------------
`timescale 1ns/1ps

module dc_source_regs (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  rp_pkg::sys_addr_t addr_i,
  input  rp_pkg::sys_data_t wdata_i,
  input  logic              wen_i,
  input  logic              ren_i,
  output rp_pkg::sys_data_t rdata_o,
  output logic              ack_o,
  output logic              err_o,
  output rp_pkg::sample_t   ofs_a_o,      // channel A offset
  output rp_pkg::sample_t   ofs_b_o,      // channel B offset
  output logic              loop_a_en_o,
  output logic              loop_b_en_o
);

  localparam int W = rp_pkg::SMP_W;

  logic [rp_pkg::REGION_LSB-1:0] ofs;
  logic                          hit_ctrl, hit_a, hit_b, hit_any;
  logic [1:0]                    ctrl_q;   // loopback enables
  rp_pkg::sample_t               ofs_a_q, ofs_b_q;
  logic                          ack_q, err_q;
  rp_pkg::sys_data_t             rdata_q;

  assign ofs      = addr_i[rp_pkg::REGION_LSB-1:0];
  assign hit_ctrl = (ofs == rp_pkg::DC_CTRL_OFS);
  assign hit_a    = (ofs == rp_pkg::DC_OFS_A_OFS);
  assign hit_b    = (ofs == rp_pkg::DC_OFS_B_OFS);
  assign hit_any  = hit_ctrl | hit_a | hit_b;

  // -------------------- write side
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      ack_q   <= 1'b0;
      err_q   <= 1'b0;
      ctrl_q  <= '0;
      ofs_a_q <= '0;
      ofs_b_q <= '0;
    end else begin
      ack_q <= wen_i | ren_i;
      err_q <= (wen_i | ren_i) & ~hit_any;              // all three are read/write
      if (wen_i && hit_ctrl) ctrl_q  <= wdata_i[1:0];
      if (wen_i && hit_a)    ofs_a_q <= wdata_i[W-1:0];
      if (wen_i && hit_b)    ofs_b_q <= wdata_i[W-1:0];
    end
  end

  // -------------------- read side
  always_ff @(posedge adc_clk) begin
    if (ren_i && hit_ctrl)   rdata_q <= rp_pkg::sys_data_t'(ctrl_q);
    else if (ren_i && hit_a) rdata_q <= {{(rp_pkg::BUS_W-W){ofs_a_q[W-1]}}, ofs_a_q};
    else if (ren_i && hit_b) rdata_q <= {{(rp_pkg::BUS_W-W){ofs_b_q[W-1]}}, ofs_b_q};
    else                     rdata_q <= '0;
  end

  assign rdata_o     = rdata_q;
  assign ack_o       = ack_q;
  assign err_o       = err_q;
  assign ofs_a_o     = ofs_a_q;
  assign ofs_b_o     = ofs_b_q;
  assign loop_a_en_o = ctrl_q[rp_pkg::DC_LOOP_A_BIT];
  assign loop_b_en_o = ctrl_q[rp_pkg::DC_LOOP_B_BIT];

endmodule

// File: verilog/adc_frontend.sv
// --------------------
// ADC front end for both channels
// the converter gives unsigned codes with a negative slope;
// keeping the MSB and inverting the rest yields two's complement
// --------------------
`timescale 1ns/1ps

module adc_frontend (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  rp_pkg::adc_raw_t adc_dat_a_i,  // CH1 pins
  input  rp_pkg::adc_raw_t adc_dat_b_i,  // CH2 pins
  output rp_pkg::sample_t  adc_a_o,      // CH1, two's complement
  output rp_pkg::sample_t  adc_b_o       // CH2, two's complement
);

  localparam int W = rp_pkg::SMP_W;

  rp_pkg::sample_t adc_a_q, adc_b_q;

  // one register stage right at the pins
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      adc_a_q <= '0;                                  // zero sample
      adc_b_q <= '0;
    end else begin
      adc_a_q <= {adc_dat_a_i[W-1], ~adc_dat_a_i[W-2:0]}; // MSB kept, rest inverted
      adc_b_q <= {adc_dat_b_i[W-1], ~adc_dat_b_i[W-2:0]};
    end
  end

  assign adc_a_o = adc_a_q;
  assign adc_b_o = adc_b_q;

endmodule

// File: verilog/dac_mixer.sv
// --------------------
// per-channel mixer: DC offset plus the ADC sample when loopback is on
// the 15-bit sum saturates to 14 bits and is registered
// --------------------
`timescale 1ns/1ps

module dac_mixer (
  input  logic            adc_clk,
  input  logic            rst_n_i,
  input  rp_pkg::sample_t adc_a_i,
  input  rp_pkg::sample_t adc_b_i,
  input  rp_pkg::sample_t ofs_a_i,
  input  rp_pkg::sample_t ofs_b_i,
  input  logic            loop_a_en_i,
  input  logic            loop_b_en_i,
  output rp_pkg::sample_t mix_a_o,
  output rp_pkg::sample_t mix_b_o
);

  localparam int SW = rp_pkg::SUM_W;

  rp_pkg::sample_t smp_a, smp_b;           // gated loopback samples
  rp_pkg::sum_t    sum_a, sum_b;
  rp_pkg::sample_t mix_a_q, mix_b_q;

  // top two bits 01 = pos. overflow, 10 = neg. overflow
  function automatic rp_pkg::sample_t saturate(input rp_pkg::sum_t sum);
    case (sum[SW-1 -: 2])
      2'b01:   return rp_pkg::SAMPLE_MAX;
      2'b10:   return rp_pkg::SAMPLE_MIN;
      default: return sum[SW-2:0];
    endcase
  endfunction

  assign smp_a = loop_a_en_i ? adc_a_i : '0;
  assign smp_b = loop_b_en_i ? adc_b_i : '0;
  assign sum_a = rp_pkg::sum_t'(ofs_a_i) + rp_pkg::sum_t'(smp_a); // sign-extended
  assign sum_b = rp_pkg::sum_t'(ofs_b_i) + rp_pkg::sum_t'(smp_b);

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      mix_a_q <= '0;
      mix_b_q <= '0;
    end else begin
      mix_a_q <= saturate(sum_a);
      mix_b_q <= saturate(sum_b);
    end
  end

  assign mix_a_o = mix_a_q;
  assign mix_b_o = mix_b_q;

  // -------------------- clamp check
  pos_sat_a: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (sum_a[SW-1 -: 2] == 2'b01) |=> (mix_a_o == rp_pkg::SAMPLE_MAX));
  pos_sat_b: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (sum_b[SW-1 -: 2] == 2'b01) |=> (mix_b_o == rp_pkg::SAMPLE_MAX));

endmodule

// File: verilog/dac_backend.sv
// --------------------
// DAC back end: two's complement back to the converter code,
// both channels sent on one bus, A when dac_sel_o is 1, B when 0
// --------------------
`timescale 1ns/1ps

module dac_backend (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  rp_pkg::sample_t   mix_a_i,
  input  rp_pkg::sample_t   mix_b_i,
  output rp_pkg::dac_code_t dac_dat_o,  // interleaved data
  output logic              dac_sel_o,  // channel select
  output logic              dac_wrt_o,  // write strobe
  output logic              dac_rst_o   // converter reset
);

  localparam int W = rp_pkg::SMP_W;

  rp_pkg::dac_code_t  dac_a_q, dac_b_q;   // channel codes
  rp_pkg::dac_phase_t phase_q;
  logic               wrt_q, rst_q;

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      dac_a_q <= {1'b0, {(W-1){1'b1}}};   // code of a zero sample, mid-scale
      dac_b_q <= {1'b0, {(W-1){1'b1}}};
      phase_q <= rp_pkg::ph_b;            // sel low in reset
      wrt_q   <= 1'b0;
      rst_q   <= 1'b1;
    end else begin
      dac_a_q <= {mix_a_i[W-1], ~mix_a_i[W-2:0]};
      dac_b_q <= {mix_b_i[W-1], ~mix_b_i[W-2:0]};
      phase_q <= (phase_q == rp_pkg::ph_a) ? rp_pkg::ph_b : rp_pkg::ph_a; // toggle
      wrt_q   <= 1'b1;
      rst_q   <= 1'b0;                    // released on the first clock
    end
  end

  assign dac_sel_o = (phase_q == rp_pkg::ph_a);
  assign dac_dat_o = (phase_q == rp_pkg::ph_a) ? dac_a_q : dac_b_q;
  assign dac_wrt_o = wrt_q;
  assign dac_rst_o = rst_q;

endmodule

// File: verilog/rp_top.sv
// --------------------
// top level of the two-channel ADC to DAC loop
// the system bus master reaches housekeeping and the DC source
// through the region decoder; the data path runs forward on adc_clk
// --------------------
`timescale 1ns/1ps

module rp_top (
  input  logic                     adc_clk,     // single system clock
  input  logic                     rst_n_i,     // sync reset, active low
  input  rp_pkg::adc_raw_t         adc_dat_a_i, // ADC CH1 pins
  input  rp_pkg::adc_raw_t         adc_dat_b_i, // ADC CH2 pins
  input  rp_pkg::sys_addr_t        sys_addr_i,
  input  rp_pkg::sys_data_t        sys_wdata_i,
  input  logic                     sys_wen_i,   // one-cycle write pulse
  input  logic                     sys_ren_i,   // one-cycle read pulse
  output rp_pkg::sys_data_t        sys_rdata_o,
  output logic                     sys_ack_o,
  output logic                     sys_err_o,
  output rp_pkg::dac_code_t        dac_dat_o,   // both channels interleaved
  output logic                     dac_sel_o,   // 1 = channel A on dac_dat_o
  output logic                     dac_wrt_o,
  output logic                     dac_rst_o,
  output logic [rp_pkg::LED_W-1:0] led_o
);

  // -------------------- bus wires
  logic              hk_wen, hk_ren, hk_ack, hk_err;
  logic              dc_wen, dc_ren, dc_ack, dc_err;
  rp_pkg::sys_data_t hk_rdata, dc_rdata;

  // -------------------- data path wires
  rp_pkg::sample_t   adc_a, adc_b;              // two's complement ADC
  rp_pkg::sample_t   ofs_a, ofs_b;              // DC offsets
  logic              loop_a_en, loop_b_en;
  rp_pkg::sample_t   mix_a, mix_b;              // saturated sums

  sys_bus_decoder i_dec (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i),
    .sys_addr_i (sys_addr_i), .sys_wen_i (sys_wen_i), .sys_ren_i (sys_ren_i),
    .sys_rdata_o (sys_rdata_o), .sys_ack_o (sys_ack_o), .sys_err_o (sys_err_o),
    .hk_wen_o (hk_wen), .hk_ren_o (hk_ren), .dc_wen_o (dc_wen), .dc_ren_o (dc_ren),
    .hk_rdata_i (hk_rdata), .hk_ack_i (hk_ack), .hk_err_i (hk_err),
    .dc_rdata_i (dc_rdata), .dc_ack_i (dc_ack), .dc_err_i (dc_err)
  );

  housekeeping_regs i_hk (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i),
    .addr_i (sys_addr_i), .wdata_i (sys_wdata_i), .wen_i (hk_wen), .ren_i (hk_ren),
    .rdata_o (hk_rdata), .ack_o (hk_ack), .err_o (hk_err), .led_o (led_o)
  );

  dc_source_regs i_dc (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i),
    .addr_i (sys_addr_i), .wdata_i (sys_wdata_i), .wen_i (dc_wen), .ren_i (dc_ren),
    .rdata_o (dc_rdata), .ack_o (dc_ack), .err_o (dc_err),
    .ofs_a_o (ofs_a), .ofs_b_o (ofs_b), .loop_a_en_o (loop_a_en), .loop_b_en_o (loop_b_en)
  );

  adc_frontend i_adc (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i), .adc_dat_b_i (adc_dat_b_i),
    .adc_a_o (adc_a), .adc_b_o (adc_b)
  );

  dac_mixer i_mix (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i),
    .adc_a_i (adc_a), .adc_b_i (adc_b), .ofs_a_i (ofs_a), .ofs_b_i (ofs_b),
    .loop_a_en_i (loop_a_en), .loop_b_en_i (loop_b_en),
    .mix_a_o (mix_a), .mix_b_o (mix_b)
  );

  dac_backend i_dac (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i),
    .mix_a_i (mix_a), .mix_b_i (mix_b),
    .dac_dat_o (dac_dat_o), .dac_sel_o (dac_sel_o),
    .dac_wrt_o (dac_wrt_o), .dac_rst_o (dac_rst_o)
  );

endmodule

// File: verification/rp_tb_tasks.svh
// --------------------
// testbench helpers, included inside rp_top_tb
// bus access with ack timeout, value checks with error counting
// and expected DAC codes from the converter and saturation rules
// --------------------
`ifndef RP_TB_TASKS_SVH
`define RP_TB_TASKS_SVH

int errors = 0;                            // failed checks
int checks = 0;                            // all checks

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
  checks++;
  if (got !== exp) begin
    $display("[ERROR] %0t ns %s expected 0x%0h got 0x%0h", $time, name, exp, got);
    errors++;
  end
endtask

// one pulse on wen or ren, then wait up to 4 cycles for ack
task automatic bus_access(input logic wr, input rp_pkg::sys_addr_t addr,
                          input rp_pkg::sys_data_t wdata,
                          output rp_pkg::sys_data_t rdata, output logic err);
  int   n;
  logic got_ack;
  @(negedge adc_clk);
  sys_addr  = addr;
  sys_wdata = wdata;
  sys_wen   = wr;
  sys_ren   = !wr;
  got_ack   = 1'b0;
  n         = 0;
  rdata     = '0;
  err       = 1'b0;
  while (!got_ack && n < 4) begin
    @(negedge adc_clk);
    sys_wen = 1'b0;                        // pulse is one cycle
    sys_ren = 1'b0;
    if (sys_ack) begin
      got_ack = 1'b1;
      rdata   = sys_rdata;
      err     = sys_err;
    end
    n++;
  end
  if (!got_ack) begin
    $display("bus access at address 0x%08h got no ack within 4 cycles", addr);
    errors++;
  end
endtask

// converter code falls as the input rises, +8191 at code 0
function automatic int code_to_value(input rp_pkg::adc_raw_t raw);
  return 8191 - int'(raw);
endfunction

// offset plus optional sample, clamped to 14 bits, back to DAC code
function automatic rp_pkg::dac_code_t expect_code(input rp_pkg::adc_raw_t raw,
                                                  input rp_pkg::sample_t ofs, input logic en);
  int sum;
  sum = int'(ofs) + (en ? code_to_value(raw) : 0);
  if (sum > 8191) sum = 8191;
  else if (sum < -8192) sum = -8192;
  return rp_pkg::dac_code_t'(8191 - sum); // DAC has the same negative slope
endfunction

`endif

// File: verification/rp_top_tb.sv
// --------------------
// testbench of the ADC to DAC loop
// checks reset state, the register bus and a table of data path rows
// --------------------
`timescale 1ns/1ps

module rp_top_tb;

  localparam int N_ROWS      = 8;
  localparam int CYCLE_LIMIT = N_ROWS * 20 + 200;
  localparam rp_pkg::sys_addr_t HK_BASE  = 32'h0000_0000;
  localparam rp_pkg::sys_addr_t DC_BASE  = 32'h0010_0000;
  localparam rp_pkg::sys_addr_t BAD_BASE = 32'h0050_0000; // region 5

  logic adc_clk, rst_n_i;
  rp_pkg::adc_raw_t  adc_dat_a, adc_dat_b;
  rp_pkg::sys_addr_t sys_addr;
  rp_pkg::sys_data_t sys_wdata, sys_rdata, rd;
  logic sys_wen, sys_ren, sys_ack, sys_err, er;
  rp_pkg::dac_code_t dac_dat;
  logic dac_sel, dac_wrt, dac_rst, prev_sel;
  logic [rp_pkg::LED_W-1:0] led;
  int seed = 88404;
  int cycles = 0;
  int rnd;

  // -------------------- stimulus table
  rp_pkg::adc_raw_t  raw_a_t [N_ROWS], raw_b_t [N_ROWS];
  rp_pkg::sample_t   ofs_a_t [N_ROWS], ofs_b_t [N_ROWS];
  logic [1:0]        loop_t  [N_ROWS];  // bit 0 A, bit 1 B
  rp_pkg::dac_code_t exp_a_t [N_ROWS], exp_b_t [N_ROWS];

  rp_top dut_i (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i),
    .adc_dat_a_i (adc_dat_a), .adc_dat_b_i (adc_dat_b),
    .sys_addr_i (sys_addr), .sys_wdata_i (sys_wdata), .sys_wen_i (sys_wen), .sys_ren_i (sys_ren),
    .sys_rdata_o (sys_rdata), .sys_ack_o (sys_ack), .sys_err_o (sys_err),
    .dac_dat_o (dac_dat), .dac_sel_o (dac_sel), .dac_wrt_o (dac_wrt), .dac_rst_o (dac_rst),
    .led_o (led)
  );

  `include "rp_tb_tasks.svh"

  initial begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;         // 4 ns period
  end

  always @(posedge adc_clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run passed the limit of %0d cycles", CYCLE_LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic build_table();
    for (int r = 0; r < N_ROWS; r++) begin
      raw_a_t[r] = rp_pkg::adc_raw_t'($random(seed));
      raw_b_t[r] = rp_pkg::adc_raw_t'($random(seed));
      rnd        = $random(seed);
      ofs_a_t[r] = {{3{rnd[10]}}, rnd[10:0]}; // small offsets keep sums mostly in range
      ofs_b_t[r] = {{3{rnd[26]}}, rnd[26:16]};
      loop_t[r]  = 2'(r);
    end
    ofs_a_t[0] = 14'h0064;                  // loopback off, +100 / -200
    ofs_b_t[0] = 14'h3F38;
    loop_t[0]  = 2'b00;
    ofs_a_t[1] = 14'h1FFF;                  // loopback off, full scale
    ofs_b_t[1] = 14'h2000;
    loop_t[1]  = 2'b00;
    raw_a_t[2] = 14'h0000;                  // A positive, B negative overflow
    raw_b_t[2] = 14'h3FFF;
    ofs_a_t[2] = 14'h0100;
    ofs_b_t[2] = 14'h3F00;
    loop_t[2]  = 2'b11;
    raw_a_t[3] = 14'h3FFF;                  // A negative, B positive overflow
    raw_b_t[3] = 14'h0000;
    ofs_a_t[3] = 14'h2000;
    ofs_b_t[3] = 14'h1FFF;
    loop_t[3]  = 2'b11;
    ofs_a_t[4] = 14'h0000;                  // plain loopback
    ofs_b_t[4] = 14'h0000;
    loop_t[4]  = 2'b11;
    loop_t[7]  = 2'b11;
    for (int r = 0; r < N_ROWS; r++) begin
      exp_a_t[r] = expect_code(raw_a_t[r], ofs_a_t[r], loop_t[r][0]);
      exp_b_t[r] = expect_code(raw_b_t[r], ofs_b_t[r], loop_t[r][1]);
    end
  endtask

  initial begin
    rst_n_i   = 1'b0;
    adc_dat_a = '0;
    adc_dat_b = '0;
    sys_addr  = '0;
    sys_wdata = '0;
    sys_wen   = 1'b0;
    sys_ren   = 1'b0;
    build_table();

    // -------------------- reset state
    repeat (4) @(posedge adc_clk);
    @(negedge adc_clk);
    check_val("dac_rst_o", 32'(dac_rst), 32'd1);
    check_val("dac_wrt_o", 32'(dac_wrt), 32'd0);
    check_val("dac_sel_o", 32'(dac_sel), 32'd0);
    check_val("led_o", 32'(led), 32'd0);
    rst_n_i = 1'b1;
    @(negedge adc_clk);
    check_val("dac_rst_o", 32'(dac_rst), 32'd0);
    check_val("dac_wrt_o", 32'(dac_wrt), 32'd1);
    prev_sel = dac_sel;
    repeat (6) begin
      @(negedge adc_clk);
      check_val("dac_sel_o", 32'(dac_sel), 32'(!prev_sel)); // toggles each cycle
      prev_sel = dac_sel;
    end

    // -------------------- register bus
    bus_access(1'b0, HK_BASE | 32'(rp_pkg::HK_ID_OFS), '0, rd, er);
    check_val("sys_rdata_o (ID)", rd, 32'h5250_0001);
    check_val("sys_err_o (ID read)", 32'(er), 32'd0);
    bus_access(1'b1, HK_BASE | 32'(rp_pkg::HK_LED_OFS), 32'h0000_00A5, rd, er);
    check_val("led_o", 32'(led), 32'h0000_00A5);
    bus_access(1'b0, HK_BASE | 32'(rp_pkg::HK_LED_OFS), '0, rd, er);
    check_val("sys_rdata_o (LED)", rd, 32'h0000_00A5);
    bus_access(1'b1, HK_BASE | 32'(rp_pkg::HK_ID_OFS), 32'h1234_5678, rd, er);
    check_val("sys_err_o (ID write)", 32'(er), 32'd1);
    bus_access(1'b0, BAD_BASE, '0, rd, er);
    check_val("sys_err_o (region 5)", 32'(er), 32'd1);
    check_val("sys_rdata_o (region 5)", rd, 32'd0);
    bus_access(1'b0, DC_BASE | 32'h0000_000C, '0, rd, er);
    check_val("sys_err_o (DC unknown)", 32'(er), 32'd1);

    // -------------------- data path rows
    for (int r = 0; r < N_ROWS; r++) begin
      bus_access(1'b1, DC_BASE | 32'(rp_pkg::DC_CTRL_OFS), {30'd0, loop_t[r]}, rd, er);
      bus_access(1'b1, DC_BASE | 32'(rp_pkg::DC_OFS_A_OFS),
                 {{18{ofs_a_t[r][13]}}, ofs_a_t[r]}, rd, er);
      bus_access(1'b1, DC_BASE | 32'(rp_pkg::DC_OFS_B_OFS),
                 {{18{ofs_b_t[r][13]}}, ofs_b_t[r]}, rd, er);
      bus_access(1'b0, DC_BASE | 32'(rp_pkg::DC_CTRL_OFS), '0, rd, er);
      check_val("sys_rdata_o (DC ctrl)", rd, {30'd0, loop_t[r]});
      bus_access(1'b0, DC_BASE | 32'(rp_pkg::DC_OFS_A_OFS), '0, rd, er);
      check_val("sys_rdata_o (DC offset A)", rd, {{18{ofs_a_t[r][13]}}, ofs_a_t[r]});
      bus_access(1'b0, DC_BASE | 32'(rp_pkg::DC_OFS_B_OFS), '0, rd, er);
      check_val("sys_rdata_o (DC offset B)", rd, {{18{ofs_b_t[r][13]}}, ofs_b_t[r]});
      adc_dat_a = raw_a_t[r];              // already on a falling edge
      adc_dat_b = raw_b_t[r];
      repeat (6) @(negedge adc_clk);       // pipeline settles
      if (!dac_sel) @(negedge adc_clk);
      check_val($sformatf("dac_dat_o A row %0d", r), 32'(dac_dat), 32'(exp_a_t[r]));
      @(negedge adc_clk);
      check_val("dac_sel_o", 32'(dac_sel), 32'd0);
      check_val($sformatf("dac_dat_o B row %0d", r), 32'(dac_dat), 32'(exp_b_t[r]));
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+verification
verilog/rp_pkg.sv
verilog/sys_bus_decoder.sv
verilog/housekeeping_regs.sv
verilog/dc_source_regs.sv
verilog/adc_frontend.sv
verilog/dac_mixer.sv
verilog/dac_backend.sv
verilog/rp_top.sv
verification/rp_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the rp_top testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module rp_top_tb -o rp_top_sim
./obj_dir/rp_top_sim | tee sim.log
if grep -q "PASS: all tests" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
